// ==== design/mipsCore_config.svh ====
`ifndef MIPS_CORE_CONFIG_SVH
`define MIPS_CORE_CONFIG_SVH

// Data and address width
`define MIPS_XLEN 32

// General purpose registers
`define MIPS_REG_COUNT 32

// First fetch address after reset
`define MIPS_RESET_PC 32'hbfc00000

`endif

// ==== design/mipsPkg.sv ====
`default_nettype none
`include "mipsCore_config.svh"

package mipsPkg;

    typedef logic [4:0] regAddr;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opCode;

    // Function field of SPECIAL words
    localparam logic [5:0] FN_JR   = 6'h08;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    typedef struct packed {
        opCode opcode;
        regAddr rs;
        regAddr rt;
        regAddr rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFields;

    typedef struct packed {
        opCode opcode;
        regAddr rs;
        regAddr rt;
        logic [15:0] imm;
    } iFields;

    typedef struct packed {
        opCode opcode;
        logic [25:0] index;
    } jFields;

    // One fetched word, read in all three formats by the decoder
    typedef union packed {
        rFields rType;
        iFields iType;
        jFields jType;
    } instrWord;

    typedef enum logic [3:0] {ADD, SUB, AND, OR, XOR, NOR, SLT, SLTU, LUI} aluOp;

    typedef enum logic [1:0] {NONE, ALU, LINK, MEM} wbSource;

    typedef enum logic [1:0] {REGFILE, FROM_MEM, FROM_WB} fwdSel;

    typedef struct packed {
        aluOp alu;
        logic useImm;
        logic signExt;
        wbSource wbSrc;
        regAddr dest;
        logic memLoad;
        logic memStore;
        logic rsDecode;
        logic rtDecode;
        logic rsExec;
        logic rtExec;
    } ctrlBundle;

    typedef struct packed {
        logic [`MIPS_XLEN-1:0] pc;
        ctrlBundle ctrl;
        regAddr rs;
        regAddr rt;
        logic [`MIPS_XLEN-1:0] rsVal;
        logic [`MIPS_XLEN-1:0] rtVal;
        logic [`MIPS_XLEN-1:0] imm;
    } execPacket;

    typedef struct packed {
        logic [`MIPS_XLEN-1:0] pc;
        wbSource wbSrc;
        regAddr dest;
        logic memLoad;
        logic memStore;
        logic [`MIPS_XLEN-1:0] result;
        logic [`MIPS_XLEN-1:0] storeData;
    } memPacket;

    typedef struct packed {
        logic [`MIPS_XLEN-1:0] pc;
        wbSource wbSrc;
        regAddr dest;
        logic [`MIPS_XLEN-1:0] result;
    } wbPacket;

    typedef struct packed {
        logic wen;
        regAddr addr;
        logic [`MIPS_XLEN-1:0] data;
    } regWrite;

    function automatic logic [`MIPS_XLEN-1:0] pickOperand(
        input fwdSel sel,
        input logic [`MIPS_XLEN-1:0] regVal,
        input logic [`MIPS_XLEN-1:0] memVal,
        input logic [`MIPS_XLEN-1:0] wbVal
    );
        case (sel)
            FROM_MEM: return memVal;
            FROM_WB:  return wbVal;
            default:  return regVal;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== design/hazardUnit.sv ====
`default_nettype none

module hazardUnit import mipsPkg::*; (
    input  logic clk,
    input  logic reset,
    input  regAddr decRs,
    input  regAddr decRt,
    input  ctrlBundle decCtrl,
    input  regAddr execRs,
    input  regAddr execRt,
    input  ctrlBundle execCtrl,
    input  wbPacket memInfo,
    input  regWrite rfWrite,
    output logic stall,
    output logic execBubble,
    output fwdSel [1:0] decodeFwd,
    output fwdSel [1:0] execFwd
);

    function automatic fwdSel forwardFrom(input regAddr r, input logic needed);
        if (needed && r != '0 && r == memInfo.dest && memInfo.wbSrc inside {ALU, LINK})
            return FROM_MEM;
        if (needed && rfWrite.wen && r == rfWrite.addr)
            return FROM_WB;
        return REGFILE;
    endfunction

    // A load one stage ahead of execute is caught while the consumer is
    // still in decode, so execute itself never has to hold
    function automatic logic operandHazard(input regAddr r, input logic needD, input logic needE);
        logic execWrites;
        logic memLoads;
        execWrites = r != '0 && r == execCtrl.dest;
        memLoads = r != '0 && r == memInfo.dest && memInfo.wbSrc == MEM;
        return (needD && (execWrites || memLoads)) || (needE && execWrites && execCtrl.memLoad);
    endfunction

    always_comb begin
        stall = operandHazard(decRs, decCtrl.rsDecode, decCtrl.rsExec)
             || operandHazard(decRt, decCtrl.rtDecode, decCtrl.rtExec);
        decodeFwd[0] = forwardFrom(decRs, 1'b1);
        decodeFwd[1] = forwardFrom(decRt, 1'b1);
        execFwd[0] = forwardFrom(execRs, execCtrl.rsExec);
        execFwd[1] = forwardFrom(execRt, execCtrl.rtExec);
    end

    assign execBubble = stall;

    // Load data only exists in writeback
    assert property (@(posedge clk) disable iff (reset)
        !(memInfo.wbSrc == MEM && memInfo.dest != '0
          && ((execCtrl.rsExec && execRs == memInfo.dest)
              || (execCtrl.rtExec && execRt == memInfo.dest))));

endmodule

`default_nettype wire

// ==== design/fetchStage.sv ====
`default_nettype none
`include "mipsCore_config.svh"

module fetchStage import mipsPkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic stall,
    input  logic redirect,
    input  logic [`MIPS_XLEN-1:0] redirectTarget,
    output logic [`MIPS_XLEN-1:0] instSramAddr,
    input  logic [`MIPS_XLEN-1:0] instSramRdata,
    output logic [`MIPS_XLEN-1:0] pc,
    output instrWord instr
);

    logic fetchValid;
    logic [`MIPS_XLEN-1:0] nextPc;

    // A stalled branch must not steer fetch with stale operands
    always_comb begin
        if (stall)
            nextPc = pc;
        else if (redirect)
            nextPc = redirectTarget;
        else
            nextPc = pc + 4;
    end

    // pc tracks the address whose word is returning this cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `MIPS_RESET_PC - 4;
            fetchValid <= 1'b0;
        end else begin
            pc <= nextPc;
            fetchValid <= 1'b1;
        end
    end

    assign instSramAddr = nextPc;
    // First word after reset is not ours, feed a nop instead
    assign instr = fetchValid ? instSramRdata : '0;

    assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== design/decodeStage.sv ====
`default_nettype none
`include "mipsCore_config.svh"

module decodeStage import mipsPkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic stall,
    input  logic [`MIPS_XLEN-1:0] pc,
    input  instrWord instr,
    input  logic [`MIPS_XLEN-1:0] rsData,
    input  logic [`MIPS_XLEN-1:0] rtData,
    input  logic [`MIPS_XLEN-1:0] memResult,
    input  regWrite rfWrite,
    input  fwdSel [1:0] decodeFwd,
    output regAddr rs,
    output regAddr rt,
    output ctrlBundle ctrl,
    output logic redirect,
    output logic [`MIPS_XLEN-1:0] redirectTarget,
    output execPacket execOut
);

    logic [`MIPS_XLEN-1:0] pcD;
    instrWord instrD;
    logic [`MIPS_XLEN-1:0] rsVal;
    logic [`MIPS_XLEN-1:0] rtVal;
    logic [`MIPS_XLEN-1:0] imm;
    logic [`MIPS_XLEN-1:0] seqPc;
    opCode op;

    always_ff @(posedge clk) begin
        if (reset) begin
            pcD <= '0;
            instrD <= '0;
        end else if (!stall) begin
            pcD <= pc;
            instrD <= instr;
        end
    end

    assign op = instrD.rType.opcode;
    assign rs = instrD.rType.rs;
    assign rt = instrD.rType.rt;

    always_comb begin
        ctrl = '0;
        case (op)
            OP_SPECIAL: begin
                ctrl.rsExec = 1'b1;
                ctrl.rtExec = 1'b1;
                ctrl.wbSrc = ALU;
                ctrl.dest = instrD.rType.rd;
                case (instrD.rType.funct)
                    FN_ADDU: ctrl.alu = ADD;
                    FN_SUBU: ctrl.alu = SUB;
                    FN_AND:  ctrl.alu = AND;
                    FN_OR:   ctrl.alu = OR;
                    FN_XOR:  ctrl.alu = XOR;
                    FN_NOR:  ctrl.alu = NOR;
                    FN_SLT:  ctrl.alu = SLT;
                    FN_SLTU: ctrl.alu = SLTU;
                    FN_JR: begin
                        ctrl = '0;
                        ctrl.rsDecode = 1'b1;
                    end
                    default: ctrl = '0;
                endcase
            end
            OP_JAL: begin
                ctrl.wbSrc = LINK;
                ctrl.dest = 5'd31;
            end
            OP_BEQ, OP_BNE: begin
                ctrl.rsDecode = 1'b1;
                ctrl.rtDecode = 1'b1;
            end
            OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_LW: begin
                ctrl.useImm = 1'b1;
                ctrl.rsExec = op != OP_LUI;
                ctrl.signExt = op inside {OP_ADDIU, OP_SLTI, OP_SLTIU, OP_LW};
                ctrl.wbSrc = op == OP_LW ? MEM : ALU;
                ctrl.memLoad = op == OP_LW;
                ctrl.dest = instrD.iType.rt;
                case (op)
                    OP_SLTI:  ctrl.alu = SLT;
                    OP_SLTIU: ctrl.alu = SLTU;
                    OP_ANDI:  ctrl.alu = AND;
                    OP_ORI:   ctrl.alu = OR;
                    OP_XORI:  ctrl.alu = XOR;
                    OP_LUI:   ctrl.alu = LUI;
                    default:  ctrl.alu = ADD;
                endcase
            end
            OP_SW: begin
                ctrl.useImm = 1'b1;
                ctrl.signExt = 1'b1;
                ctrl.rsExec = 1'b1;
                ctrl.rtExec = 1'b1;
                ctrl.memStore = 1'b1;
            end
            default: ctrl = '0;
        endcase
    end

    assign rsVal = pickOperand(decodeFwd[0], rsData, memResult, rfWrite.data);
    assign rtVal = pickOperand(decodeFwd[1], rtData, memResult, rfWrite.data);
    assign imm = ctrl.signExt ? {{16{instrD.iType.imm[15]}}, instrD.iType.imm}
                              : {16'h0, instrD.iType.imm};
    assign seqPc = pcD + 4;

    always_comb begin
        redirect = 1'b0;
        redirectTarget = seqPc + {{14{instrD.iType.imm[15]}}, instrD.iType.imm, 2'b00};
        case (op)
            OP_BEQ: redirect = rsVal == rtVal;
            OP_BNE: redirect = rsVal != rtVal;
            OP_J, OP_JAL: begin
                redirect = 1'b1;
                redirectTarget = {seqPc[31:28], instrD.jType.index, 2'b00};
            end
            OP_SPECIAL: begin
                if (instrD.rType.funct == FN_JR) begin
                    redirect = 1'b1;
                    redirectTarget = rsVal;
                end
            end
            default: redirect = 1'b0;
        endcase
    end

    assign execOut = '{pc: pcD, ctrl: ctrl, rs: rs, rt: rt,
                       rsVal: rsVal, rtVal: rtVal, imm: imm};

endmodule

`default_nettype wire

// ==== design/registerFile.sv ====
`default_nettype none
`include "mipsCore_config.svh"

module registerFile import mipsPkg::*; (
    input  logic clk,
    input  logic reset,
    input  regAddr rsAddr,
    input  regAddr rtAddr,
    output logic [`MIPS_XLEN-1:0] rsData,
    output logic [`MIPS_XLEN-1:0] rtData,
    input  regWrite rfWrite
);

    logic [`MIPS_XLEN-1:0] regs [`MIPS_REG_COUNT];

    always_ff @(posedge clk) begin
        if (rfWrite.wen)
            regs[rfWrite.addr] <= rfWrite.data;
    end

    // Writeback data bypasses the array
    function automatic logic [`MIPS_XLEN-1:0] readReg(input regAddr a);
        if (a == '0)
            return '0;
        if (rfWrite.wen && rfWrite.addr == a)
            return rfWrite.data;
        return regs[a];
    endfunction

    assign rsData = readReg(rsAddr);
    assign rtData = readReg(rtAddr);

    assert property (@(posedge clk) disable iff (reset) !(rfWrite.wen && rfWrite.addr == '0));

endmodule

`default_nettype wire

// ==== design/executeStage.sv ====
`default_nettype none
`include "mipsCore_config.svh"

module executeStage import mipsPkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic execBubble,
    input  execPacket execIn,
    input  logic [`MIPS_XLEN-1:0] memResult,
    input  regWrite rfWrite,
    input  fwdSel [1:0] execFwd,
    output regAddr execRs,
    output regAddr execRt,
    output ctrlBundle execCtrl,
    output memPacket memOut
);

    execPacket ex;
    logic [`MIPS_XLEN-1:0] opA;
    logic [`MIPS_XLEN-1:0] rtFwd;
    logic [`MIPS_XLEN-1:0] opB;
    logic [`MIPS_XLEN-1:0] aluOut;

    always_ff @(posedge clk) begin
        if (reset || execBubble)
            ex <= '0;
        else
            ex <= execIn;
    end

    assign opA = pickOperand(execFwd[0], ex.rsVal, memResult, rfWrite.data);
    assign rtFwd = pickOperand(execFwd[1], ex.rtVal, memResult, rfWrite.data);
    assign opB = ex.ctrl.useImm ? ex.imm : rtFwd;

    always_comb begin
        case (ex.ctrl.alu)
            SUB:     aluOut = opA - opB;
            AND:     aluOut = opA & opB;
            OR:      aluOut = opA | opB;
            XOR:     aluOut = opA ^ opB;
            NOR:     aluOut = ~(opA | opB);
            SLT:     aluOut = {31'h0, $signed(opA) < $signed(opB)};
            SLTU:    aluOut = {31'h0, opA < opB};
            LUI:     aluOut = {opB[15:0], 16'h0};
            default: aluOut = opA + opB;
        endcase
    end

    assign execRs = ex.rs;
    assign execRt = ex.rt;
    assign execCtrl = ex.ctrl;

    // Link skips the delay slot
    assign memOut = '{pc: ex.pc, wbSrc: ex.ctrl.wbSrc, dest: ex.ctrl.dest,
                      memLoad: ex.ctrl.memLoad, memStore: ex.ctrl.memStore,
                      result: ex.ctrl.wbSrc == LINK ? ex.pc + 8 : aluOut,
                      storeData: rtFwd};

endmodule

`default_nettype wire

// ==== design/memoryStage.sv ====
`default_nettype none
`include "mipsCore_config.svh"

module memoryStage import mipsPkg::*; (
    input  logic clk,
    input  logic reset,
    input  memPacket memIn,
    output logic dataSramEn,
    output logic [3:0] dataSramWen,
    output logic [`MIPS_XLEN-1:0] dataSramAddr,
    output logic [`MIPS_XLEN-1:0] dataSramWdata,
    output logic [`MIPS_XLEN-1:0] memResult,
    output wbPacket wbOut
);

    memPacket mp;

    always_ff @(posedge clk) begin
        if (reset)
            mp <= '0;
        else
            mp <= memIn;
    end

    // Word accesses only
    assign dataSramEn = mp.memLoad || mp.memStore;
    assign dataSramWen = {4{mp.memStore}};
    assign dataSramAddr = mp.result;
    assign dataSramWdata = mp.storeData;

    assign memResult = mp.result;
    assign wbOut = '{pc: mp.pc, wbSrc: mp.wbSrc, dest: mp.dest, result: mp.result};

    // Each request is one aligned word, either a load or a store
    assert property (@(posedge clk) disable iff (reset)
        dataSramEn |-> (mp.memLoad != mp.memStore) && dataSramAddr[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== design/writebackStage.sv ====
`default_nettype none
`include "mipsCore_config.svh"

module writebackStage import mipsPkg::*; (
    input  logic clk,
    input  logic reset,
    input  wbPacket wbIn,
    input  logic [`MIPS_XLEN-1:0] dataSramRdata,
    output regWrite rfWrite,
    output logic [`MIPS_XLEN-1:0] debugWbPc,
    output logic [3:0] debugWbRfWen,
    output regAddr debugWbRfWnum,
    output logic [`MIPS_XLEN-1:0] debugWbRfWdata
);

    wbPacket wb;

    always_ff @(posedge clk) begin
        if (reset)
            wb <= '0;
        else
            wb <= wbIn;
    end

    // Load data arrives from the SRAM this cycle
    assign rfWrite.wen = wb.wbSrc != NONE && wb.dest != '0;
    assign rfWrite.addr = wb.dest;
    assign rfWrite.data = wb.wbSrc == MEM ? dataSramRdata : wb.result;

    assign debugWbPc = wb.pc;
    assign debugWbRfWen = {4{rfWrite.wen}};
    assign debugWbRfWnum = wb.dest;
    assign debugWbRfWdata = rfWrite.data;

endmodule

`default_nettype wire

// ==== design/mipsCore.sv ====
`default_nettype none
`include "mipsCore_config.svh"

module mipsCore import mipsPkg::*; (
    input  logic clk,
    input  logic reset,
    output logic [`MIPS_XLEN-1:0] instSramAddr,
    input  logic [`MIPS_XLEN-1:0] instSramRdata,
    output logic dataSramEn,
    output logic [3:0] dataSramWen,
    output logic [`MIPS_XLEN-1:0] dataSramAddr,
    output logic [`MIPS_XLEN-1:0] dataSramWdata,
    input  logic [`MIPS_XLEN-1:0] dataSramRdata,
    output logic [`MIPS_XLEN-1:0] debugWbPc,
    output logic [3:0] debugWbRfWen,
    output regAddr debugWbRfWnum,
    output logic [`MIPS_XLEN-1:0] debugWbRfWdata
);

    logic stall;
    logic execBubble;
    fwdSel [1:0] decodeFwd;
    fwdSel [1:0] execFwd;

    logic [`MIPS_XLEN-1:0] fetchPc;
    instrWord fetchInstr;
    logic redirect;
    logic [`MIPS_XLEN-1:0] redirectTarget;

    regAddr decRs;
    regAddr decRt;
    ctrlBundle decCtrl;
    logic [`MIPS_XLEN-1:0] rsData;
    logic [`MIPS_XLEN-1:0] rtData;
    execPacket execIn;

    regAddr execRs;
    regAddr execRt;
    ctrlBundle execCtrl;
    memPacket memIn;

    logic [`MIPS_XLEN-1:0] memResult;
    wbPacket wbIn;
    regWrite rfWrite;

    fetchStage fetch_i (
        .clk(clk), .reset(reset), .stall(stall),
        .redirect(redirect), .redirectTarget(redirectTarget),
        .instSramAddr(instSramAddr), .instSramRdata(instSramRdata),
        .pc(fetchPc), .instr(fetchInstr)
    );

    decodeStage decode_i (
        .clk(clk), .reset(reset), .stall(stall),
        .pc(fetchPc), .instr(fetchInstr),
        .rsData(rsData), .rtData(rtData),
        .memResult(memResult), .rfWrite(rfWrite), .decodeFwd(decodeFwd),
        .rs(decRs), .rt(decRt), .ctrl(decCtrl),
        .redirect(redirect), .redirectTarget(redirectTarget),
        .execOut(execIn)
    );

    registerFile regFile_i (
        .clk(clk), .reset(reset),
        .rsAddr(decRs), .rtAddr(decRt),
        .rsData(rsData), .rtData(rtData),
        .rfWrite(rfWrite)
    );

    hazardUnit hazard_i (
        .clk(clk), .reset(reset),
        .decRs(decRs), .decRt(decRt), .decCtrl(decCtrl),
        .execRs(execRs), .execRt(execRt), .execCtrl(execCtrl),
        .memInfo(wbIn), .rfWrite(rfWrite),
        .stall(stall), .execBubble(execBubble),
        .decodeFwd(decodeFwd), .execFwd(execFwd)
    );

    executeStage execute_i (
        .clk(clk), .reset(reset), .execBubble(execBubble),
        .execIn(execIn), .memResult(memResult), .rfWrite(rfWrite),
        .execFwd(execFwd),
        .execRs(execRs), .execRt(execRt), .execCtrl(execCtrl),
        .memOut(memIn)
    );

    memoryStage memory_i (
        .clk(clk), .reset(reset), .memIn(memIn),
        .dataSramEn(dataSramEn), .dataSramWen(dataSramWen),
        .dataSramAddr(dataSramAddr), .dataSramWdata(dataSramWdata),
        .memResult(memResult), .wbOut(wbIn)
    );

    writebackStage writeback_i (
        .clk(clk), .reset(reset), .wbIn(wbIn), .dataSramRdata(dataSramRdata),
        .rfWrite(rfWrite),
        .debugWbPc(debugWbPc), .debugWbRfWen(debugWbRfWen),
        .debugWbRfWnum(debugWbRfWnum), .debugWbRfWdata(debugWbRfWdata)
    );

endmodule

`default_nettype wire

// ==== tests/mipsCore_tb.sv ====
`default_nettype none
`include "mipsCore_config.svh"

module mipsCore_tb import mipsPkg::*; ();

    localparam int IMEM_WORDS = 256;
    localparam int DMEM_WORDS = 256;
    localparam int DRAIN_CYCLES = 20;

    typedef struct packed {
        logic [`MIPS_XLEN-1:0] pc;
        regAddr dest;
        logic [`MIPS_XLEN-1:0] data;
    } wbEntry;

    typedef struct packed {
        logic [`MIPS_XLEN-1:0] addr;
        logic [`MIPS_XLEN-1:0] data;
    } storeEntry;

    logic clk;
    logic reset;
    logic [`MIPS_XLEN-1:0] instSramAddr;
    logic [`MIPS_XLEN-1:0] instSramRdata;
    logic dataSramEn;
    logic [3:0] dataSramWen;
    logic [`MIPS_XLEN-1:0] dataSramAddr;
    logic [`MIPS_XLEN-1:0] dataSramWdata;
    logic [`MIPS_XLEN-1:0] dataSramRdata;
    logic [`MIPS_XLEN-1:0] debugWbPc;
    logic [3:0] debugWbRfWen;
    regAddr debugWbRfWnum;
    logic [`MIPS_XLEN-1:0] debugWbRfWdata;

    logic [`MIPS_XLEN-1:0] imem [IMEM_WORDS];
    logic [`MIPS_XLEN-1:0] dmem [DMEM_WORDS];
    wbEntry wbExpected [$];
    storeEntry storeExpected [$];
    int wbIdx;
    int storeIdx;
    int wbErrors;
    int storeErrors;
    int otherErrors;
    logic traceLoaded;

    mipsCore dut_i (
        .clk(clk), .reset(reset),
        .instSramAddr(instSramAddr), .instSramRdata(instSramRdata),
        .dataSramEn(dataSramEn), .dataSramWen(dataSramWen),
        .dataSramAddr(dataSramAddr), .dataSramWdata(dataSramWdata),
        .dataSramRdata(dataSramRdata),
        .debugWbPc(debugWbPc), .debugWbRfWen(debugWbRfWen),
        .debugWbRfWnum(debugWbRfWnum), .debugWbRfWdata(debugWbRfWdata)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // Words outside the loaded program read as nops
    function automatic logic [`MIPS_XLEN-1:0] instrAt(input logic [`MIPS_XLEN-1:0] addr);
        logic [`MIPS_XLEN-1:0] offset;
        offset = addr - `MIPS_RESET_PC;
        if (offset[1:0] == 2'b00 && offset < IMEM_WORDS * 4)
            return imem[offset >> 2];
        return '0;
    endfunction

    task automatic loadTrace();
        int fd;
        int n;
        int c;
        logic [7:0] tag;
        logic [`MIPS_XLEN-1:0] f0;
        logic [`MIPS_XLEN-1:0] f1;
        logic [`MIPS_XLEN-1:0] f2;
        wbEntry w;
        storeEntry s;
        fd = $fopen("tests/mipsCore_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open tests/mipsCore_trace.txt");
            otherErrors++;
            return;
        end
        while ($fscanf(fd, " %c", tag) == 1) begin
            n = 0;
            case (tag)
                "I": begin
                    n = $fscanf(fd, "%h %h", f0, f1);
                    if (n == 2 && f0 - `MIPS_RESET_PC < IMEM_WORDS * 4)
                        imem[(f0 - `MIPS_RESET_PC) >> 2] = f1;
                    else
                        n = -1;
                end
                "D": begin
                    n = $fscanf(fd, "%h %h", f0, f1);
                    if (n == 2 && f0 < DMEM_WORDS * 4)
                        dmem[f0 >> 2] = f1;
                    else
                        n = -1;
                end
                "W": begin
                    n = $fscanf(fd, "%h %h %h", f0, f1, f2);
                    w.pc = f0;
                    w.dest = f1[4:0];
                    w.data = f2;
                    if (n == 3)
                        wbExpected.push_back(w);
                    else
                        n = -1;
                end
                "S": begin
                    n = $fscanf(fd, "%h %h", f0, f1);
                    s.addr = f0;
                    s.data = f1;
                    if (n == 2)
                        storeExpected.push_back(s);
                    else
                        n = -1;
                end
                "#": begin
                    do begin
                        c = $fgetc(fd);
                    end while (c != "\n" && c != -1);
                end
                default: n = -1;
            endcase
            if (n < 0) begin
                $display("Malformed trace entry with tag %c", tag);
                otherErrors++;
            end
        end
        $fclose(fd);
    endtask

    // One-cycle synchronous SRAMs
    always @(posedge clk) begin
        instSramRdata <= instrAt(instSramAddr);
        if (dataSramEn) begin
            if (dataSramWen != 4'h0)
                dmem[dataSramAddr[9:2]] <= dataSramWdata;
            else
                dataSramRdata <= dmem[dataSramAddr[9:2]];
        end
    end

    task automatic checkWriteback();
        wbEntry exp;
        assert (wbIdx < wbExpected.size()) else begin
            $display("%0t: register %0d written at pc %h after the last expected writeback",
                     $time, debugWbRfWnum, debugWbPc);
            otherErrors++;
        end
        if (wbIdx < wbExpected.size()) begin
            exp = wbExpected[wbIdx];
            assert (debugWbPc == exp.pc) else begin
                $display("[FAIL] %0t debugWbPc expected %h got %h", $time, exp.pc, debugWbPc);
                wbErrors++;
            end
            assert (debugWbRfWnum == exp.dest) else begin
                $display("[FAIL] %0t debugWbRfWnum expected %0d got %0d",
                         $time, exp.dest, debugWbRfWnum);
                wbErrors++;
            end
            assert (debugWbRfWdata == exp.data) else begin
                $display("[FAIL] %0t debugWbRfWdata expected %h got %h",
                         $time, exp.data, debugWbRfWdata);
                wbErrors++;
            end
            assert (debugWbRfWen == 4'hf) else begin
                $display("[FAIL] %0t debugWbRfWen expected f got %h", $time, debugWbRfWen);
                wbErrors++;
            end
            wbIdx++;
        end
    endtask

    task automatic checkStore();
        storeEntry exp;
        assert (storeIdx < storeExpected.size()) else begin
            $display("%0t: store to %h after the last expected store", $time, dataSramAddr);
            otherErrors++;
        end
        if (storeIdx < storeExpected.size()) begin
            exp = storeExpected[storeIdx];
            assert (dataSramAddr == exp.addr) else begin
                $display("[FAIL] %0t dataSramAddr expected %h got %h", $time, exp.addr, dataSramAddr);
                storeErrors++;
            end
            assert (dataSramWdata == exp.data) else begin
                $display("[FAIL] %0t dataSramWdata expected %h got %h",
                         $time, exp.data, dataSramWdata);
                storeErrors++;
            end
            storeIdx++;
        end
    endtask

    // Outputs settle well before the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            if (debugWbRfWen != 4'h0)
                checkWriteback();
            if (dataSramWen != 4'h0)
                checkStore();
            if (dataSramEn) begin
                assert (dataSramAddr[31:10] == '0 && dataSramAddr[1:0] == 2'b00) else begin
                    $display("%0t: data access to %h is unaligned or outside the data memory",
                             $time, dataSramAddr);
                    otherErrors++;
                end
            end
        end
    end

    task automatic reportCounts();
        $display("Error counts: writeback %0d, store %0d, other %0d",
                 wbErrors, storeErrors, otherErrors);
    endtask

    initial begin
        reset = 1'b1;
        instSramRdata = '0;
        dataSramRdata = '0;
        wbIdx = 0;
        storeIdx = 0;
        wbErrors = 0;
        storeErrors = 0;
        otherErrors = 0;
        traceLoaded = 1'b0;
        for (int i = 0; i < IMEM_WORDS; i++)
            imem[i] = '0;
        for (int i = 0; i < DMEM_WORDS; i++)
            dmem[i] = '0;
        loadTrace();
        traceLoaded = 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        while (wbIdx < wbExpected.size() || storeIdx < storeExpected.size())
            @(negedge clk);
        // Catch stray writes after the last expected one
        repeat (DRAIN_CYCLES) @(negedge clk);
        reportCounts();
        if (wbErrors + storeErrors + otherErrors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

    initial begin
        wait (traceLoaded);
        repeat (200 + 12 * wbExpected.size()) @(posedge clk);
        $display("Timeout with %0d of %0d writebacks and %0d of %0d stores seen",
                 wbIdx, wbExpected.size(), storeIdx, storeExpected.size());
        reportCounts();
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+design
design/mipsPkg.sv
design/hazardUnit.sv
design/fetchStage.sv
design/decodeStage.sv
design/registerFile.sv
design/executeStage.sv
design/memoryStage.sv
design/writebackStage.sv
design/mipsCore.sv
tests/mipsCore_tb.sv

// ==== tests/mipsCore_trace.txt ====
# I addr word, D addr word, W pc reg data, S addr data, all hex
# W and S entries are listed in retirement order
I bfc00000 3c011234
I bfc00004 34215678
I bfc00008 2402fffd
I bfc0000c 00221821
I bfc00010 00612023
I bfc00014 00612824
I bfc00018 00a13025
I bfc0001c 00223826
I bfc00020 00204027
I bfc00024 0041482a
I bfc00028 0041502b
I bfc0002c 284bfffe
I bfc00030 2c2cffff
I bfc00034 304d8ff0
I bfc00038 382effff
I bfc0003c 8c0f0100 # lw then use
I bfc00040 01ef8021
I bfc00044 ac100104
I bfc00048 8c110104
I bfc0004c ac110108
I bfc00050 8c12010c
I bfc00054 16400003 # bne on loaded value
I bfc00058 24130001
I bfc0005c 24140055
I bfc00060 24140066
I bfc00064 10720004
I bfc00068 26740002
I bfc0006c 16940005
I bfc00070 2695ffff
I bfc00074 12b50003
I bfc00078 24160022
I bfc0007c 24160033
I bfc00080 24160044
I bfc00084 0ff00028 # jal to bfc000a0
I bfc00088 24170007
I bfc0008c 26f80001
I bfc00090 0bf0002c
I bfc00094 03180021
I bfc00098 24190099
I bfc0009c 00000000
I bfc000a0 27f90000
I bfc000a4 03200008 # jr through fresh value
I bfc000a8 ffffffff
I bfc000ac 241a0bad
I bfc000b0 241a600d
I bfc000b4 ac1a0110
I bfc000b8 0bf0002e
I bfc000bc 00000000
D 00000100 0badf00d
D 0000010c 0000007b
W bfc00000 01 12340000
W bfc00004 01 12345678
W bfc00008 02 fffffffd
W bfc0000c 03 12345675
W bfc00010 04 fffffffd
W bfc00014 05 12345670
W bfc00018 06 12345678
W bfc0001c 07 edcba985
W bfc00020 08 edcba987
W bfc00024 09 00000001
W bfc00028 0a 00000000
W bfc0002c 0b 00000001
W bfc00030 0c 00000001
W bfc00034 0d 00008ff0
W bfc00038 0e 1234a987
W bfc0003c 0f 0badf00d
W bfc00040 10 175be01a
W bfc00048 11 175be01a
W bfc00050 12 0000007b
W bfc00058 13 00000001
W bfc00068 14 00000003
W bfc00070 15 00000002
W bfc00078 16 00000022
W bfc00084 1f bfc0008c
W bfc00088 17 00000007
W bfc000a0 19 bfc0008c
W bfc0008c 18 00000008
W bfc000b0 1a 0000600d
S 00000104 175be01a
S 00000108 175be01a
S 00000110 0000600d
